/* common/accel_ctrl_pkg.sv */
/*
 * widths, typedefs and state encodings shared by the accelerator control unit
 */
package accel_ctrl_pkg;

	parameter int patch_w = 8;

	typedef logic [patch_w-1:0] patch_cnt_t;
	typedef logic [1:0]         wb_change_t;
	typedef logic [3:0]         return_sel_t;   // {upsample, pool, add, conv}
	typedef logic [2:0]         kernel_size_t;

	// weight/bias change codes
	localparam wb_change_t wb_none        = 2'b00;
	localparam wb_change_t wb_weight      = 2'b01;
	localparam wb_change_t wb_weight_bias = 2'b11;

	typedef enum logic [2:0] {
		order_none     = 3'd0,
		order_conv     = 3'd1,
		order_add      = 3'd2,
		order_pool     = 3'd3,
		order_upsample = 3'd4
	} order_t;

	typedef enum logic [2:0] {
		task_idle, task_wait_order, task_wait_conv, task_wait_add, task_wait_op
	} task_state_t;

	typedef enum logic [2:0] {
		conv_idle, conv_change_wb, conv_wait_wb, conv_wait_calc,
		conv_check_in, conv_wait_return, conv_check_out, conv_finish
	} conv_state_t;

	typedef enum logic [1:0] {
		add_idle, add_wait_done, add_wait_return, add_finish
	} add_state_t;

	typedef enum logic [2:0] {
		op_idle, op_load, op_wait_compute, op_wait_return, op_check_in, op_finish
	} op_state_t;

endpackage

/* hdl/task_sequencer.sv */
/*
 * task and layer order FSM
 * starts one layer sequencer per order and waits for its done pulse
 */
`timescale 1ns/10ps

module task_sequencer (
	input  logic                   system_clk,
	input  logic                   rst_n,
	input  logic                   task_start,
	input  logic                   task_finish,
	input  logic                   calculate_start,
	input  accel_ctrl_pkg::order_t order,
	input  logic                   conv_done,
	input  logic                   add_done,
	input  logic                   op_done,
	output logic                   conv_start,
	output logic                   add_start,
	output logic                   op_start,
	output accel_ctrl_pkg::order_t active_order,
	output logic                   calculate_finish
);
	import accel_ctrl_pkg::*;

	task_state_t state;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= task_idle;
			active_order <= order_none;
			conv_start   <= 1'b0;
			add_start    <= 1'b0;
			op_start     <= 1'b0;
		end else begin
			conv_start <= 1'b0;
			add_start  <= 1'b0;
			op_start   <= 1'b0;
			case (state)
				task_idle: begin
					if (task_start)
						state <= task_wait_order;
				end
				task_wait_order: begin
					if (calculate_start) begin
						case (order)
							order_conv: begin
								state        <= task_wait_conv;
								conv_start   <= 1'b1;
								active_order <= order;
							end
							order_add: begin
								state        <= task_wait_add;
								add_start    <= 1'b1;
								active_order <= order;
							end
							order_pool, order_upsample: begin
								state        <= task_wait_op;
								op_start     <= 1'b1;
								active_order <= order;
							end
							default: ;  // unknown order, stay
						endcase
					end else if (task_finish) begin
						state <= task_idle;
					end
				end
				task_wait_conv: if (conv_done) state <= task_wait_order;
				task_wait_add:  if (add_done) state <= task_wait_order;
				task_wait_op:   if (op_done) state <= task_wait_order;
				default:        state <= task_idle;
			endcase
		end
	end

	assign calculate_finish = (state == task_idle) || (state == task_wait_order);

endmodule

/* layer_seq/conv_sequencer.sv */
/*
 * convolution sequencer
 * input patches nested in output patches, weight/bias swap and return strobes
 */
`timescale 1ns/10ps

module conv_sequencer (
	input  logic                       system_clk,
	input  logic                       rst_n,
	input  logic                       conv_start,
	input  logic                       weight_bias_ready,
	input  logic                       compute_finish,
	input  logic                       return_finish,
	input  accel_ctrl_pkg::patch_cnt_t feature_input_patch_num,
	input  accel_ctrl_pkg::patch_cnt_t feature_output_patch_num,
	output logic                       conv_done,
	output logic                       conv_busy,
	output accel_ctrl_pkg::wb_change_t change_weight_bias,
	output logic                       load_feature_begin,
	output logic                       compute_begin,
	output logic                       return_req,
	output logic                       refresh_return_addr,
	output logic                       free_feature_read_addr,
	output logic                       output_buffer_done,
	output logic                       direct_out,
	output logic                       bias_or_adder_feature
);
	import accel_ctrl_pkg::*;

	conv_state_t state;
	patch_cnt_t  in_cnt;
	patch_cnt_t  out_cnt;
	logic        last_in;
	logic        wb_first;   // first cycle of the weight/bias wait
	logic        in_done;

	assign last_in = (in_cnt == patch_cnt_t'(feature_input_patch_num - 1'b1));
	assign in_done = (in_cnt == feature_input_patch_num);

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= conv_idle;
		end else begin
			case (state)
				conv_idle:        if (conv_start) state <= conv_change_wb;
				conv_change_wb:   state <= conv_wait_wb;
				conv_wait_wb:     if (weight_bias_ready) state <= conv_wait_calc;
				conv_wait_calc:   if (compute_finish) state <= conv_check_in;
				conv_check_in:    state <= in_done ? conv_wait_return : conv_change_wb;
				conv_wait_return: if (return_finish) state <= conv_check_out;
				conv_check_out: begin
					if (out_cnt == feature_output_patch_num)
						state <= conv_finish;
					else
						state <= conv_change_wb;
				end
				default:          state <= conv_idle;   // conv_finish
			endcase
		end
	end

	// patch counters
	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			in_cnt  <= '0;
			out_cnt <= '0;
		end else begin
			if (state == conv_wait_calc && compute_finish)
				in_cnt <= in_cnt + 1'b1;
			else if (state == conv_wait_return)
				in_cnt <= '0;
			if (state == conv_wait_return && return_finish)
				out_cnt <= out_cnt + 1'b1;
			else if (state == conv_finish)
				out_cnt <= '0;
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			change_weight_bias     <= wb_none;
			wb_first               <= 1'b0;
			load_feature_begin     <= 1'b0;
			compute_begin          <= 1'b0;
			return_req             <= 1'b0;
			refresh_return_addr    <= 1'b0;
			free_feature_read_addr <= 1'b0;
			direct_out             <= 1'b0;
		end else begin
			if (state == conv_change_wb)
				change_weight_bias <= (in_cnt == '0) ? wb_weight_bias : wb_weight;
			else if (state != conv_wait_wb || weight_bias_ready)
				change_weight_bias <= wb_none;
			wb_first               <= (state == conv_change_wb);
			load_feature_begin     <= wb_first;
			compute_begin          <= (state == conv_wait_wb) && weight_bias_ready;
			return_req             <= (state == conv_change_wb) && last_in;
			refresh_return_addr    <= (state == conv_change_wb) && last_in && (out_cnt == '0);
			free_feature_read_addr <= (state == conv_check_in) && in_done;
			if (state == conv_change_wb)
				direct_out <= last_in;   // only the last input patch goes out
			else if (state == conv_finish)
				direct_out <= 1'b0;
		end
	end

	assign output_buffer_done    = (state == conv_wait_return);
	assign bias_or_adder_feature = (in_cnt == '0);
	assign conv_done             = (state == conv_finish);
	assign conv_busy             = (state != conv_idle);

endmodule

/* layer_seq/add_sequencer.sv */
/*
 * element-wise add sequencer, one load/compute/return pass
 */
`timescale 1ns/10ps

module add_sequencer (
	input  logic system_clk,
	input  logic rst_n,
	input  logic add_start,
	input  logic compute_finish,
	input  logic return_finish,
	output logic add_done,
	output logic add_busy,
	output logic load_feature_begin,
	output logic compute_begin,
	output logic return_req,
	output logic refresh_return_addr,
	output logic free_feature_read_addr,
	output logic output_buffer_done
);
	import accel_ctrl_pkg::*;

	add_state_t state;
	logic       launch;   // all start strobes fire together

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state                  <= add_idle;
			launch                 <= 1'b0;
			free_feature_read_addr <= 1'b0;
		end else begin
			launch                 <= (state == add_idle) && add_start;
			free_feature_read_addr <= (state == add_finish);
			case (state)
				add_idle:        if (add_start) state <= add_wait_done;
				add_wait_done:   if (compute_finish) state <= add_wait_return;
				add_wait_return: if (return_finish) state <= add_finish;
				default:         state <= add_idle;
			endcase
		end
	end

	assign load_feature_begin  = launch;
	assign compute_begin       = launch;
	assign return_req          = launch;
	assign refresh_return_addr = launch;
	assign output_buffer_done  = (state == add_wait_return);
	assign add_done            = (state == add_finish);
	assign add_busy            = (state != add_idle);

endmodule

/* layer_seq/operator_sequencer.sv */
/*
 * pool and upsample sequencer over the input patches
 */
`timescale 1ns/10ps

module operator_sequencer (
	input  logic                       system_clk,
	input  logic                       rst_n,
	input  logic                       op_start,
	input  logic                       is_upsample,
	input  logic                       compute_finish,
	input  logic                       return_finish,
	input  logic                       upsample_buffer_empty,
	input  accel_ctrl_pkg::patch_cnt_t feature_input_patch_num,
	output logic                       op_done,
	output logic                       op_busy,
	output logic                       load_feature_begin,
	output logic                       compute_begin,
	output logic                       return_req,
	output logic                       refresh_return_addr,
	output logic                       free_feature_read_addr,
	output logic                       output_buffer_done
);
	import accel_ctrl_pkg::*;

	op_state_t  state;
	patch_cnt_t in_cnt;
	logic       in_done;
	logic       buffer_done;

	assign in_done = (in_cnt == feature_input_patch_num);
	// upsample must drain its buffer first
	assign buffer_done = is_upsample ? upsample_buffer_empty : 1'b1;

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= op_idle;
			in_cnt <= '0;
		end else begin
			case (state)
				op_idle:         if (op_start) state <= op_load;
				op_load:         state <= op_wait_compute;
				op_wait_compute: if (compute_finish) state <= op_wait_return;
				op_wait_return: begin
					if (return_finish) begin
						state  <= op_check_in;
						in_cnt <= in_cnt + 1'b1;
					end
				end
				op_check_in: begin
					if (in_done) begin
						state  <= op_finish;
						in_cnt <= '0;
					end else begin
						state <= op_load;
					end
				end
				default:         state <= op_idle;
			endcase
		end
	end

	always_ff @(posedge system_clk or negedge rst_n) begin
		if (!rst_n) begin
			load_feature_begin     <= 1'b0;
			compute_begin          <= 1'b0;
			return_req             <= 1'b0;
			refresh_return_addr    <= 1'b0;
			free_feature_read_addr <= 1'b0;
		end else begin
			load_feature_begin     <= (state == op_load);
			compute_begin          <= (state == op_load);
			return_req             <= (state == op_load);
			refresh_return_addr    <= (state == op_load) && (in_cnt == '0);   // first patch
			free_feature_read_addr <= (state == op_check_in) && in_done;
		end
	end

	assign output_buffer_done = (state == op_wait_return) && buffer_done;
	assign op_done            = (state == op_finish);
	assign op_busy            = (state != op_idle);

endmodule

/* hdl/datapath_steer.sv */
/*
 * strobe merge and datapath steering
 * return path select, kernel size, cache rebuild, feature ready mux
 */
`timescale 1ns/10ps

module datapath_steer #(
	parameter int conv_kernel_size = 3,
	parameter int pool_kernel_size = 5
) (
	input  logic                         conv_busy,
	input  logic                         add_busy,
	input  logic                         op_busy,
	input  accel_ctrl_pkg::order_t       active_order,
	input  logic                         direct_out,
	input  logic                         return_buffer_ready,
	input  logic                         upsample_ready,
	input  logic                         conv_load_feature_begin,
	input  logic                         conv_compute_begin,
	input  logic                         conv_return_req,
	input  logic                         conv_refresh_return_addr,
	input  logic                         conv_free_feature_read_addr,
	input  logic                         conv_output_buffer_done,
	input  logic                         add_load_feature_begin,
	input  logic                         add_compute_begin,
	input  logic                         add_return_req,
	input  logic                         add_refresh_return_addr,
	input  logic                         add_free_feature_read_addr,
	input  logic                         add_output_buffer_done,
	input  logic                         op_load_feature_begin,
	input  logic                         op_compute_begin,
	input  logic                         op_return_req,
	input  logic                         op_refresh_return_addr,
	input  logic                         op_free_feature_read_addr,
	input  logic                         op_output_buffer_done,
	output logic                         load_feature_begin,
	output logic                         compute_begin,
	output logic                         return_req,
	output logic                         refresh_return_addr,
	output logic                         free_feature_read_addr,
	output logic                         output_buffer_done,
	output accel_ctrl_pkg::return_sel_t  return_select,
	output accel_ctrl_pkg::kernel_size_t kernel_size,
	output logic                         rebuild_structure,
	output logic                         feature_output_ready,
	output logic                         is_upsample
);
	import accel_ctrl_pkg::*;

	logic pool_working;
	logic upsample_working;

	// one sequencer busy at a time, so a plain OR is enough
	assign load_feature_begin     = conv_load_feature_begin | add_load_feature_begin
	                              | op_load_feature_begin;
	assign compute_begin          = conv_compute_begin | add_compute_begin | op_compute_begin;
	assign return_req             = conv_return_req | add_return_req | op_return_req;
	assign refresh_return_addr    = conv_refresh_return_addr | add_refresh_return_addr
	                              | op_refresh_return_addr;
	assign free_feature_read_addr = conv_free_feature_read_addr | add_free_feature_read_addr
	                              | op_free_feature_read_addr;
	assign output_buffer_done     = conv_output_buffer_done | add_output_buffer_done
	                              | op_output_buffer_done;

	assign is_upsample      = (active_order == order_upsample);
	assign upsample_working = op_busy && is_upsample;
	assign pool_working     = op_busy && (active_order == order_pool);

	assign return_select     = {upsample_working, pool_working, add_busy, conv_busy};
	assign rebuild_structure = pool_working;   // pool window in the row cache
	assign kernel_size       = pool_working ? kernel_size_t'(pool_kernel_size)
	                                        : kernel_size_t'(conv_kernel_size);

	assign feature_output_ready = (direct_out && conv_busy) ? return_buffer_ready :
	                              upsample_working ? upsample_ready : 1'b1;

endmodule

/* hdl/accel_control_top.sv */
/*
 * accelerator control unit top level
 * task FSM, three layer sequencers and the datapath steering
 */
`timescale 1ns/10ps

module accel_control_top #(
	parameter int conv_kernel_size = 3,
	parameter int pool_kernel_size = 5
) (
	input  logic                         system_clk,
	input  logic                         rst_n,
	input  logic                         task_start,
	input  logic                         task_finish,
	input  logic                         calculate_start,
	input  accel_ctrl_pkg::order_t       order,
	input  accel_ctrl_pkg::patch_cnt_t   feature_input_patch_num,
	input  accel_ctrl_pkg::patch_cnt_t   feature_output_patch_num,
	input  logic                         weight_bias_ready,
	input  logic                         compute_finish,
	input  logic                         return_finish,
	input  logic                         return_buffer_ready,
	input  logic                         upsample_ready,
	input  logic                         upsample_buffer_empty,
	output logic                         calculate_finish,
	output accel_ctrl_pkg::wb_change_t   change_weight_bias,
	output logic                         load_feature_begin,
	output logic                         compute_begin,
	output logic                         return_req,
	output logic                         refresh_return_addr,
	output logic                         free_feature_read_addr,
	output logic                         output_buffer_done,
	output logic                         direct_out,
	output logic                         bias_or_adder_feature,
	output accel_ctrl_pkg::return_sel_t  return_select,
	output accel_ctrl_pkg::kernel_size_t kernel_size,
	output logic                         rebuild_structure,
	output logic                         feature_output_ready
);
	import accel_ctrl_pkg::*;

	order_t active_order;
	logic   conv_start, add_start, op_start;
	logic   conv_done, add_done, op_done;
	logic   conv_busy, add_busy, op_busy;
	logic   is_upsample;

	// per-sequencer strobes, merged in datapath_steer
	logic   conv_load_feature_begin, conv_compute_begin, conv_return_req;
	logic   conv_refresh_return_addr, conv_free_feature_read_addr, conv_output_buffer_done;
	logic   add_load_feature_begin, add_compute_begin, add_return_req;
	logic   add_refresh_return_addr, add_free_feature_read_addr, add_output_buffer_done;
	logic   op_load_feature_begin, op_compute_begin, op_return_req;
	logic   op_refresh_return_addr, op_free_feature_read_addr, op_output_buffer_done;

	task_sequencer u_task_sequencer (.*);

	conv_sequencer u_conv_sequencer (
		.*,
		.load_feature_begin     (conv_load_feature_begin),
		.compute_begin          (conv_compute_begin),
		.return_req             (conv_return_req),
		.refresh_return_addr    (conv_refresh_return_addr),
		.free_feature_read_addr (conv_free_feature_read_addr),
		.output_buffer_done     (conv_output_buffer_done)
	);

	add_sequencer u_add_sequencer (
		.*,
		.load_feature_begin     (add_load_feature_begin),
		.compute_begin          (add_compute_begin),
		.return_req             (add_return_req),
		.refresh_return_addr    (add_refresh_return_addr),
		.free_feature_read_addr (add_free_feature_read_addr),
		.output_buffer_done     (add_output_buffer_done)
	);

	operator_sequencer u_operator_sequencer (
		.*,
		.load_feature_begin     (op_load_feature_begin),
		.compute_begin          (op_compute_begin),
		.return_req             (op_return_req),
		.refresh_return_addr    (op_refresh_return_addr),
		.free_feature_read_addr (op_free_feature_read_addr),
		.output_buffer_done     (op_output_buffer_done)
	);

	datapath_steer #(
		.conv_kernel_size (conv_kernel_size),
		.pool_kernel_size (pool_kernel_size)
	) u_datapath_steer (.*);

endmodule

/* dv/accel_control_tb.sv */
/*
 * testbench for the accelerator control unit
 * clock, reset, datapath responders, layer stimulus and checks
 */
`timescale 1ns/10ps

module accel_control_tb;
	import accel_ctrl_pkg::*;

	localparam int conv_ks = 3;
	localparam int pool_ks = 5;
	localparam logic [31:0] seed = 32'd66225;

	logic system_clk, rst_n, task_start, task_finish, calculate_start;
	order_t order;
	patch_cnt_t feature_input_patch_num, feature_output_patch_num;
	logic weight_bias_ready, compute_finish, return_finish;
	logic return_buffer_ready, upsample_ready, upsample_buffer_empty;
	logic calculate_finish, load_feature_begin, compute_begin, return_req;
	logic refresh_return_addr, free_feature_read_addr, output_buffer_done;
	logic direct_out, bias_or_adder_feature, rebuild_structure, feature_output_ready;
	wb_change_t change_weight_bias;
	return_sel_t return_select;
	kernel_size_t kernel_size;

	// one random stream per process
	logic [31:0] stim_rng = seed;
	logic [31:0] compute_rng = seed;
	logic [31:0] weight_rng = seed;
	logic [31:0] return_rng = seed;
	logic [31:0] ready_rng = seed;
	int n_load, n_compute, n_return, n_refresh, n_free, n_wb3, n_wb1;
	int layer_kind;   // 0 none, else the order under test
	int n_in_cur;
	int conv_idx;
	logic add_window;
	wb_change_t wb_prev;

	accel_control_top #(
		.conv_kernel_size (conv_ks),
		.pool_kernel_size (pool_ks)
	) accel_control_top_inst (.*);

	initial begin
		system_clk = 1'b0;
		forever #5 system_clk = ~system_clk;
	end

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input int exp, input int act);
		assert (exp == act)
			else fail_now($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
				$time, name, exp, act));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int in_range(input logic [31:0] r, input int lo, input int hi);
		return lo + int'(r % 32'(hi - lo + 1));
	endfunction

	task automatic clear_counts();
		n_load = 0;
		n_compute = 0;
		n_return = 0;
		n_refresh = 0;
		n_free = 0;
		n_wb3 = 0;
		n_wb1 = 0;
		conv_idx = 0;
	endtask

	// properties that hold on every cycle
	a_direct: assert property (@(posedge system_clk) disable iff (!rst_n)
		(return_req && return_select == 4'b0001) |-> direct_out)
		else fail_now("direct_out low at a convolution return request");
	a_kernel: assert property (@(posedge system_clk) disable iff (!rst_n)
		kernel_size == (rebuild_structure ? kernel_size_t'(pool_ks) : kernel_size_t'(conv_ks)))
		else fail_now("kernel size does not follow the pool working state");
	a_rebuild: assert property (@(posedge system_clk) disable iff (!rst_n)
		rebuild_structure == (return_select == 4'b0100))
		else fail_now("rebuild_structure differs from the pool select");
	a_onehot: assert property (@(posedge system_clk) disable iff (!rst_n) $onehot0(return_select))
		else fail_now("return_select has more than one bit set");

	// edge counters and per-cycle checks
	always @(posedge system_clk) begin
		if (rst_n) begin
			if (load_feature_begin) n_load++;
			if (return_req) n_return++;
			if (refresh_return_addr) n_refresh++;
			if (free_feature_read_addr) n_free++;
			if (change_weight_bias != wb_prev && change_weight_bias == 2'b11) n_wb3++;
			if (change_weight_bias != wb_prev && change_weight_bias == 2'b01) n_wb1++;
			if (compute_begin) begin
				n_compute++;
				if (layer_kind == 1) begin
					check_eq("bias_or_adder_feature", int'(conv_idx % n_in_cur == 0),
						int'(bias_or_adder_feature));
					conv_idx++;
				end
			end
			if (layer_kind == 2) begin
				check_eq("output_buffer_done", int'(add_window), int'(output_buffer_done));
				if (compute_finish) add_window = 1'b1;
				if (return_finish) add_window = 1'b0;
			end
			if (layer_kind == 4 && !upsample_buffer_empty)
				check_eq("output_buffer_done", 0, int'(output_buffer_done));
			if (return_select == 4'b1000)
				check_eq("feature_output_ready", int'(upsample_ready), int'(feature_output_ready));
		end
		wb_prev = change_weight_bias;
	end

	// datapath responders
	always begin : compute_responder
		int d;
		@(posedge system_clk);
		if (rst_n && compute_begin) begin
			compute_rng = xorshift(compute_rng);
			d = in_range(compute_rng, 0, 5);
			repeat (d) @(posedge system_clk);
			compute_finish <= 1'b1;
			@(posedge system_clk);
			compute_finish <= 1'b0;
		end
	end

	always begin : weight_responder
		int d;
		@(posedge system_clk);
		if (rst_n && change_weight_bias != 2'b00) begin
			weight_rng = xorshift(weight_rng);
			d = in_range(weight_rng, 0, 5);
			repeat (d) @(posedge system_clk);
			weight_bias_ready <= 1'b1;
			@(posedge system_clk);
			weight_bias_ready <= 1'b0;
		end
	end

	always begin : return_responder
		int d;
		int t;
		@(posedge system_clk);
		if (rst_n && return_req) begin
			t = 0;
			while (!output_buffer_done) begin
				@(posedge system_clk);
				t++;
				if (t > 2000) fail_now("timeout waiting for output_buffer_done");
			end
			return_rng = xorshift(return_rng);
			d = in_range(return_rng, 0, 5);
			repeat (d) @(posedge system_clk);
			return_finish <= 1'b1;
			@(posedge system_clk);
			return_finish <= 1'b0;
		end
	end

	always @(posedge system_clk) begin : ready_toggle
		ready_rng = xorshift(ready_rng);
		upsample_ready      <= ready_rng[0];
		return_buffer_ready <= ~ready_rng[0];
	end

	task automatic run_layer(input order_t ord, input int n_in, input int n_out,
			input logic [3:0] sel);
		int t;
		@(posedge system_clk);
		order                    <= ord;
		feature_input_patch_num  <= patch_cnt_t'(n_in);
		feature_output_patch_num <= patch_cnt_t'(n_out);
		calculate_start          <= 1'b1;
		@(posedge system_clk);
		calculate_start <= 1'b0;
		t = 0;
		while (calculate_finish) begin
			@(posedge system_clk);
			t++;
			if (t > 20) fail_now("calculate_finish did not fall after calculate_start");
		end
		t = 0;
		while (!calculate_finish) begin
			@(posedge system_clk);
			if (!calculate_finish)
				check_eq("return_select", int'(sel), int'(return_select));
			t++;
			if (t > 5000) fail_now("timeout waiting for calculate_finish");
		end
		@(posedge system_clk);   // add frees its read address as calculate_finish rises
	endtask

	// a fixed window in which nothing may happen
	task automatic expect_quiet(input order_t ord);
		clear_counts();
		@(posedge system_clk);
		order           <= ord;
		calculate_start <= 1'b1;
		@(posedge system_clk);
		calculate_start <= 1'b0;
		repeat (10) begin
			@(posedge system_clk);
			check_eq("calculate_finish", 1, int'(calculate_finish));
		end
		check_eq("strobe count", 0, n_load + n_compute + n_return + n_refresh + n_free);
	endtask

	initial begin
		int n, m;
		rst_n = 1'b0;
		task_start = 1'b0;
		task_finish = 1'b0;
		calculate_start = 1'b0;
		order = order_none;
		feature_input_patch_num = '0;
		feature_output_patch_num = '0;
		weight_bias_ready = 1'b0;
		compute_finish = 1'b0;
		return_finish = 1'b0;
		return_buffer_ready = 1'b0;
		upsample_ready = 1'b0;
		upsample_buffer_empty = 1'b1;
		layer_kind = 0;
		n_in_cur = 1;
		add_window = 1'b0;
		wb_prev = 2'b00;
		clear_counts();
		repeat (5) @(posedge system_clk);
		rst_n <= 1'b1;
		@(posedge system_clk);
		check_eq("calculate_finish", 1, int'(calculate_finish));
		check_eq("change_weight_bias", 0, int'(change_weight_bias));
		check_eq("direct_out", 0, int'(direct_out));
		check_eq("output_buffer_done", 0, int'(output_buffer_done));
		check_eq("compute_begin", 0, int'(compute_begin));
		check_eq("load_feature_begin", 0, int'(load_feature_begin));
		check_eq("return_req", 0, int'(return_req));
		check_eq("refresh_return_addr", 0, int'(refresh_return_addr));
		check_eq("free_feature_read_addr", 0, int'(free_feature_read_addr));

		task_start <= 1'b1;
		@(posedge system_clk);
		task_start <= 1'b0;
		expect_quiet(order_none);

		// convolution
		stim_rng = xorshift(stim_rng);
		n = in_range(stim_rng, 1, 4);
		stim_rng = xorshift(stim_rng);
		m = in_range(stim_rng, 1, 4);
		clear_counts();
		n_in_cur = n;
		layer_kind = 1;
		run_layer(order_conv, n, m, 4'b0001);
		check_eq("compute_begin count", n * m, n_compute);
		check_eq("return_req count", m, n_return);
		check_eq("weight and bias change count", m, n_wb3);
		check_eq("weight change count", (n - 1) * m, n_wb1);
		check_eq("free_feature_read_addr count", m, n_free);
		check_eq("refresh_return_addr count", 1, n_refresh);

		// add
		clear_counts();
		add_window = 1'b0;
		layer_kind = 2;
		run_layer(order_add, 1, 1, 4'b0010);
		check_eq("load_feature_begin count", 1, n_load);
		check_eq("compute_begin count", 1, n_compute);
		check_eq("return_req count", 1, n_return);
		check_eq("refresh_return_addr count", 1, n_refresh);
		check_eq("free_feature_read_addr count", 1, n_free);

		// pool
		stim_rng = xorshift(stim_rng);
		n = in_range(stim_rng, 1, 4);
		clear_counts();
		layer_kind = 3;
		run_layer(order_pool, n, 1, 4'b0100);
		check_eq("compute_begin count", n, n_compute);
		check_eq("return_req count", n, n_return);
		check_eq("refresh_return_addr count", 1, n_refresh);

		// upsample, buffer drains late
		stim_rng = xorshift(stim_rng);
		n = in_range(stim_rng, 1, 4);
		clear_counts();
		upsample_buffer_empty <= 1'b0;
		layer_kind = 4;
		fork
			begin
				repeat (30) @(posedge system_clk);
				upsample_buffer_empty <= 1'b1;
			end
		join_none
		run_layer(order_upsample, n, 1, 4'b1000);
		check_eq("compute_begin count", n, n_compute);
		layer_kind = 0;

		// task end
		task_finish <= 1'b1;
		@(posedge system_clk);
		task_finish <= 1'b0;
		expect_quiet(order_conv);

		$display("All checks passed");
		$finish;
	end

endmodule

/* accel_control_top.f */
common/accel_ctrl_pkg.sv
hdl/task_sequencer.sv
layer_seq/conv_sequencer.sv
layer_seq/add_sequencer.sv
layer_seq/operator_sequencer.sv
hdl/datapath_steer.sv
hdl/accel_control_top.sv
dv/accel_control_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module accel_control_tb \
	-f accel_control_top.f \
	-o accel_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/accel_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
